//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_command_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cmd_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatcher
    import cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rx_tvalid,
    input  logic      rx_tlast,
    input  word_t     rx_data,
    output logic      rx_tready,
    input  logic      busy_done,      // OR of the engine done pulses
    output word_t     serial_num,
    output cmd_word_u cmd_word,
    output logic      cmd_had_last,   // command word closed the frame
    output logic      run_loopback,
    output logic      run_reg_read,
    output logic      run_reg_write,
    output logic      cmd_idle
);

    logic [DSP_STATE_W-1:0] state;
    cmd_word_u              rx_cmd;         // incoming word seen as a command
    logic                   code_known;
    logic                   needs_payload;  // read and write carry at least one more word

    assign rx_cmd.raw    = rx_data;
    assign code_known    = rx_cmd.fields.code inside {CC_LOOPBACK, CC_RD_REG, CC_WR_REG};
    assign needs_payload = rx_cmd.fields.code != CC_LOOPBACK;

    // only ready while a word is offered, so the port rests low
    assign rx_tready = rx_tvalid && (state == D_IDLE || state == D_CMD || state == D_DRAIN);

    //////////////////////////////////////////////////////////////////////
    // header FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= D_IDLE;
            cmd_had_last <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (rx_tvalid && !rx_tlast) state <= D_CMD;  // a lone word is dropped
                end
                D_CMD: begin
                    if (rx_tvalid) begin
                        cmd_had_last <= rx_tlast;
                        if (code_known && !(rx_tlast && needs_payload)) begin
                            state <= D_RUN;
                        end else if (!rx_tlast) begin
                            state <= D_DRAIN;                    // unknown code, skip the rest
                        end else begin
                            state <= D_IDLE;                     // frame already over
                        end
                    end
                end
                D_RUN:   state <= D_WAIT;
                D_WAIT: begin
                    if (busy_done) state <= D_IDLE;
                end
                D_DRAIN: begin
                    if (rx_tvalid && rx_tlast) state <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // header words, picked up as they are accepted
    always_ff @(posedge clk) begin
        if (state == D_IDLE && rx_tvalid) serial_num <= rx_data;
        if (state == D_CMD && rx_tvalid)  cmd_word   <= rx_cmd;
    end

    //////////////////////////////////////////////////////////////////////
    // engine start, one cycle after the command word

    assign run_loopback  = (state == D_RUN) && (cmd_word.fields.code == CC_LOOPBACK);
    assign run_reg_read  = (state == D_RUN) && (cmd_word.fields.code == CC_RD_REG);
    assign run_reg_write = (state == D_RUN) && (cmd_word.fields.code == CC_WR_REG);

    assign cmd_idle = state == D_IDLE;

endmodule

`default_nettype wire

//--- cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream words and the command word

    localparam int WORD_W = 32;                   // width of one stream word
    localparam int CODE_W = 5;                    // command code in the low bits
    localparam int ARG_W  = WORD_W - CODE_W;      // rest of the command word

    typedef logic [WORD_W-1:0] word_t;

    // one command word, echoed whole or split for decoding
    typedef union packed {
        word_t raw;                               // whole word, for echo and inverse
        struct packed {
            logic [ARG_W-1:0]  arg;               // upper bits, passed through untouched
            logic [CODE_W-1:0] code;              // selects the engine
        } fields;
    } cmd_word_u;

    localparam logic [CODE_W-1:0] CC_LOOPBACK = 5'd1;  // echo the payload
    localparam logic [CODE_W-1:0] CC_RD_REG   = 5'd2;  // read one register
    localparam logic [CODE_W-1:0] CC_WR_REG   = 5'd3;  // write one register

    //////////////////////////////////////////////////////////////////////
    // register bank map

    localparam word_t NUM_REGS         = 32'd5;   // numbers at or above are illegal
    localparam word_t REG_FW_ID        = 32'd0;   // read only
    localparam word_t REG_NUM_BURSTS   = 32'd1;
    localparam word_t REG_WAVEFORM_GAP = 32'd2;
    localparam word_t REG_SCRATCH      = 32'd3;   // full width, no side effects
    localparam word_t REG_XADC_TEMP    = 32'd4;   // read only

    localparam word_t FW_ID_VALUE = 32'h0c0d_0102; // firmware id word

    localparam int BURSTS_W = 23;
    localparam int GAP_W    = 22;
    localparam int TEMP_W   = 16;

    //////////////////////////////////////////////////////////////////////
    // state encodings

    localparam int DSP_STATE_W = 3;
    localparam logic [DSP_STATE_W-1:0] D_IDLE  = 3'd0;  // waiting for a serial number
    localparam logic [DSP_STATE_W-1:0] D_CMD   = 3'd1;  // waiting for the command word
    localparam logic [DSP_STATE_W-1:0] D_RUN   = 3'd2;  // one cycle, fires the run pulse
    localparam logic [DSP_STATE_W-1:0] D_DRAIN = 3'd3;  // throw words away up to tlast
    localparam logic [DSP_STATE_W-1:0] D_WAIT  = 3'd4;  // an engine owns the streams

    // shared by both engines, each uses a subset
    localparam int ENG_STATE_W = 3;
    localparam logic [ENG_STATE_W-1:0] E_IDLE = 3'd0;
    localparam logic [ENG_STATE_W-1:0] E_RX   = 3'd1;   // take payload or register number
    localparam logic [ENG_STATE_W-1:0] E_DATA = 3'd2;   // take the write data
    localparam logic [ENG_STATE_W-1:0] E_READ = 3'd3;   // issue the register read
    localparam logic [ENG_STATE_W-1:0] E_CSN  = 3'd4;   // serial number on tx
    localparam logic [ENG_STATE_W-1:0] E_CMD  = 3'd5;   // command or inverse on tx
    localparam logic [ENG_STATE_W-1:0] E_WORD = 3'd6;   // echo or read data on tx

endpackage

`default_nettype wire

//--- command_top.sv
`timescale 1ns/1ps
`default_nettype none

module command_top
    import cmd_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  word_t               rx_data,
    input  logic                rx_tvalid,
    input  logic                rx_tlast,
    output logic                rx_tready,
    output word_t               tx_data,
    output logic                tx_tvalid,
    output logic                tx_tlast,
    input  logic                tx_tready,
    input  logic [TEMP_W-1:0]   xadc_temp,
    output logic [BURSTS_W-1:0] num_bursts,
    output logic [GAP_W-1:0]    waveform_gap,
    output logic                cmd_idle
);

    word_t     serial_num;
    cmd_word_u cmd_word;
    word_t     rd_data;
    word_t     tx_word;   // one registered word toward tx
    logic      cmd_had_last, run_loopback, run_reg_read, run_reg_write, busy_done;
    logic      dsp_rx_tready, lb_rx_tready, ra_rx_tready;
    logic      lb_tx_tvalid, lb_tx_tlast, ra_tx_tvalid, ra_tx_tlast;
    logic      lb_send_csn, lb_send_cmd, ra_send_csn, ra_send_cmd;
    logic      send_csn, send_cmd, send_inv_cmd, send_rx_data, send_reg_data;
    logic      lb_done, ra_done, reg_num_le, rd_en, wr_en, illegal_reg_num;

    //////////////////////////////////////////////////////////////////////
    // strobe merges, only one owner is active at a time

    assign rx_tready = dsp_rx_tready || lb_rx_tready || ra_rx_tready;
    assign tx_tvalid = lb_tx_tvalid || ra_tx_tvalid;
    assign tx_tlast  = lb_tx_tlast || ra_tx_tlast;
    assign send_csn  = lb_send_csn || ra_send_csn;
    assign send_cmd  = lb_send_cmd || ra_send_cmd;
    assign busy_done = lb_done || ra_done;

    // tx word select
    always_ff @(posedge clk) begin
        if (send_csn)           tx_word <= serial_num;
        else if (send_cmd)      tx_word <= cmd_word.raw;
        else if (send_inv_cmd)  tx_word <= ~cmd_word.raw;   // failed command
        else if (send_rx_data)  tx_word <= rx_data;         // loopback echo
        else if (send_reg_data) tx_word <= rd_data;
    end
    assign tx_data = tx_word;

    cmd_dispatcher cmd_dispatcher_inst (
        .clk(clk), .reset(reset), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
        .rx_data(rx_data), .rx_tready(dsp_rx_tready), .busy_done(busy_done),
        .serial_num(serial_num), .cmd_word(cmd_word), .cmd_had_last(cmd_had_last),
        .run_loopback(run_loopback), .run_reg_read(run_reg_read),
        .run_reg_write(run_reg_write), .cmd_idle(cmd_idle)
    );

    loopback_engine loopback_engine_inst (
        .clk(clk), .reset(reset), .run(run_loopback), .cmd_had_last(cmd_had_last),
        .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(lb_rx_tready),
        .tx_tvalid(lb_tx_tvalid), .tx_tlast(lb_tx_tlast), .tx_tready(tx_tready),
        .send_csn(lb_send_csn), .send_cmd(lb_send_cmd), .send_rx_data(send_rx_data),
        .done(lb_done)
    );

    reg_access_engine reg_access_engine_inst (
        .clk(clk), .reset(reset), .run_read(run_reg_read), .run_write(run_reg_write),
        .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(ra_rx_tready),
        .tx_tvalid(ra_tx_tvalid), .tx_tlast(ra_tx_tlast), .tx_tready(tx_tready),
        .illegal_reg_num(illegal_reg_num), .send_csn(ra_send_csn), .send_cmd(ra_send_cmd),
        .send_inv_cmd(send_inv_cmd), .send_reg_data(send_reg_data),
        .reg_num_le(reg_num_le), .rd_en(rd_en), .wr_en(wr_en), .done(ra_done)
    );

    register_bank register_bank_inst (
        .clk(clk), .reset(reset), .rx_data(rx_data), .reg_num_le(reg_num_le),
        .rd_en(rd_en), .wr_en(wr_en), .xadc_temp(xadc_temp), .rd_data(rd_data),
        .illegal_reg_num(illegal_reg_num), .num_bursts(num_bursts),
        .waveform_gap(waveform_gap)
    );

endmodule

`default_nettype wire

//--- loopback_engine.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_engine
    import cmd_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic run,            // one-cycle start from the dispatcher
    input  logic cmd_had_last,   // empty payload, tlast goes on the command
    input  logic rx_tvalid,
    input  logic rx_tlast,
    output logic rx_tready,
    output logic tx_tvalid,
    output logic tx_tlast,
    input  logic tx_tready,
    output logic send_csn,
    output logic send_cmd,
    output logic send_rx_data,
    output logic done
);

    logic [ENG_STATE_W-1:0] state;
    logic                   echo_last;   // tlast of the word now being echoed

    assign rx_tready = state == E_RX;    // at most one echo in flight
    assign tx_tvalid = state inside {E_CSN, E_CMD, E_WORD};
    assign tx_tlast  = (state == E_CMD && cmd_had_last) || (state == E_WORD && echo_last);

    // word select strobes, tx_word loads on the same edge
    assign send_csn     = state == E_IDLE && run;
    assign send_cmd     = state == E_CSN && tx_tready;
    assign send_rx_data = state == E_RX && rx_tvalid;

    assign done = tx_tvalid && tx_tready && tx_tlast;  // last word of the response taken

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= E_IDLE;
            echo_last <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (run) state <= E_CSN;
                end
                E_CSN: begin
                    if (tx_tready) state <= E_CMD;
                end
                E_CMD: begin
                    if (tx_tready) state <= cmd_had_last ? E_IDLE : E_RX;
                end
                E_RX: begin
                    if (rx_tvalid) begin
                        echo_last <= rx_tlast;
                        state     <= E_WORD;
                    end
                end
                E_WORD: begin
                    if (tx_tready) state <= echo_last ? E_IDLE : E_RX;
                end
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- project.f
cmd_pkg.sv
cmd_dispatcher.sv
loopback_engine.sv
reg_access_engine.sv
register_bank.sv
command_top.sv
tb_command_top.sv

//--- reg_access_engine.sv
`timescale 1ns/1ps
`default_nettype none

module reg_access_engine
    import cmd_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic run_read,
    input  logic run_write,
    input  logic rx_tvalid,
    input  logic rx_tlast,
    output logic rx_tready,
    output logic tx_tvalid,
    output logic tx_tlast,
    input  logic tx_tready,
    input  logic illegal_reg_num,   // from the bank, valid after reg_num_le
    output logic send_csn,
    output logic send_cmd,
    output logic send_inv_cmd,
    output logic send_reg_data,
    output logic reg_num_le,
    output logic rd_en,
    output logic wr_en,
    output logic done
);

    logic [ENG_STATE_W-1:0] state;
    logic                   is_write;   // which command started us
    logic                   short_cmd;  // response ends after the command word

    //////////////////////////////////////////////////////////////////////
    // rx side and bank controls

    assign rx_tready  = state inside {E_RX, E_DATA};
    assign reg_num_le = state == E_RX && rx_tvalid;
    assign wr_en      = state == E_DATA && rx_tvalid && !illegal_reg_num;
    assign rd_en      = state == E_READ && !is_write && !illegal_reg_num;

    // serial number loads once the payload is in
    assign send_csn = (state == E_DATA && rx_tvalid) || state == E_READ;

    //////////////////////////////////////////////////////////////////////
    // tx side

    assign short_cmd = is_write || illegal_reg_num;
    assign tx_tvalid = state inside {E_CSN, E_CMD, E_WORD};
    assign tx_tlast  = (state == E_CMD && short_cmd) || state == E_WORD;

    assign send_cmd      = state == E_CSN && tx_tready && !illegal_reg_num;
    assign send_inv_cmd  = state == E_CSN && tx_tready && illegal_reg_num;
    assign send_reg_data = state == E_CMD && tx_tready && !short_cmd;

    assign done = tx_tvalid && tx_tready && tx_tlast;

    //////////////////////////////////////////////////////////////////////
    // command sequence

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= E_IDLE;
            is_write <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (run_read || run_write) begin
                        is_write <= run_write;
                        state    <= E_RX;
                    end
                end
                E_RX: begin
                    // a write frame that stops at the number gets no data phase
                    if (rx_tvalid) state <= (is_write && !rx_tlast) ? E_DATA : E_READ;
                end
                E_DATA: begin
                    if (rx_tvalid) state <= E_CSN;
                end
                E_READ:  state <= E_CSN;             // illegal flag settled by now
                E_CSN: begin
                    if (tx_tready) state <= E_CMD;
                end
                E_CMD: begin
                    if (tx_tready) state <= short_cmd ? E_IDLE : E_WORD;
                end
                E_WORD: begin
                    if (tx_tready) state <= E_IDLE;
                end
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank
    import cmd_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  word_t               rx_data,          // register number or write data
    input  logic                reg_num_le,
    input  logic                rd_en,
    input  logic                wr_en,
    input  logic [TEMP_W-1:0]   xadc_temp,
    output word_t               rd_data,
    output logic                illegal_reg_num,
    output logic [BURSTS_W-1:0] num_bursts,
    output logic [GAP_W-1:0]    waveform_gap
);

    word_t reg_num;   // number of the register being accessed
    word_t scratch;
    word_t rd_mux;

    //////////////////////////////////////////////////////////////////////
    // register number

    always_ff @(posedge clk) begin
        if (reg_num_le) reg_num <= rx_data;
    end

    assign illegal_reg_num = reg_num >= NUM_REGS;

    //////////////////////////////////////////////////////////////////////
    // writable registers, narrow ones keep the low bits

    always_ff @(posedge clk) begin
        if (reset) begin
            num_bursts   <= '0;
            waveform_gap <= '0;
            scratch      <= '0;
        end else if (wr_en) begin
            case (reg_num)
                REG_NUM_BURSTS:   num_bursts   <= rx_data[BURSTS_W-1:0];
                REG_WAVEFORM_GAP: waveform_gap <= rx_data[GAP_W-1:0];
                REG_SCRATCH:      scratch      <= rx_data;
                default: ;                                 // id and temp are read only
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side

    always_comb begin
        case (reg_num)
            REG_FW_ID:        rd_mux = FW_ID_VALUE;
            REG_NUM_BURSTS:   rd_mux = word_t'(num_bursts);    // zeros above
            REG_WAVEFORM_GAP: rd_mux = word_t'(waveform_gap);
            REG_SCRATCH:      rd_mux = scratch;
            REG_XADC_TEMP:    rd_mux = word_t'(xadc_temp);
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) rd_data <= rd_mux;   // ready the cycle after rd_en
    end

endmodule

`default_nettype wire

//--- tb_command_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_command_top
    import cmd_pkg::*;
;
    localparam int NT = 20;                       // number of table entries
    localparam int CYCLE_LIMIT = NT * 200;
    localparam logic [TEMP_W-1:0] TEMP_VALUE = 16'h3c5a;

    logic clk, reset, rx_tvalid, rx_tlast, rx_tready, tx_tvalid, tx_tlast, tx_tready;
    logic cmd_idle;
    word_t rx_data, tx_data;
    logic [TEMP_W-1:0]   xadc_temp;
    logic [BURSTS_W-1:0] num_bursts;
    logic [GAP_W-1:0]    waveform_gap;

    word_t frame [NT][6];                         // stimulus, tlast on the last word
    word_t expect_w [NT][6];                      // expected response words
    int    flen [NT];
    int    elen [NT];                             // zero means no response
    logic  bp [NT];                               // random back-pressure and rx gaps
    logic [BURSTS_W-1:0] exp_bursts [NT];
    logic [GAP_W-1:0]    exp_gap [NT];

    word_t got_data [$];                          // collected tx words
    logic  got_last [$];
    integer seed = 32'hc177_542a;
    logic  bp_on = 1'b0;
    logic  rx_gap = 1'b0;                         // idle cycle before the next rx word
    int    errors = 0;
    int    failed_tests = 0;
    int    cycles = 0;

    command_top command_top_inst (
        .clk(clk), .reset(reset), .rx_data(rx_data), .rx_tvalid(rx_tvalid),
        .rx_tlast(rx_tlast), .rx_tready(rx_tready), .tx_data(tx_data),
        .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
        .xadc_temp(xadc_temp), .num_bursts(num_bursts), .waveform_gap(waveform_gap),
        .cmd_idle(cmd_idle)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                        // 20 ns period

    //////////////////////////////////////////////////////////////////////
    // tx ready and rx gap pattern, collector

    always @(posedge clk) begin
        tx_tready <= bp_on ? (($random(seed) & 1) != 0) : 1'b1;
        rx_gap    <= bp_on ? (($random(seed) & 1) != 0) : 1'b0;
        if (!reset && tx_tvalid && tx_tready) begin
            got_data.push_back(tx_data);
            got_last.push_back(tx_tlast);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_config(input string name, input logic [BURSTS_W-1:0] exp,
                                input logic [BURSTS_W-1:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // table

    task automatic set_test(input int t, input int n, input word_t f0, f1, f2, f3,
                            input int m, input word_t e0, e1, e2, e3, e4, input logic b);
        frame[t]    = '{f0, f1, f2, f3, 32'h0, 32'h0};
        expect_w[t] = '{e0, e1, e2, e3, e4, 32'h0};
        flen[t] = n;
        elen[t] = m;
        bp[t]   = b;
    endtask

    task automatic fill_table();
        word_t lb, rd, wr, z;
        lb = {27'h55e_0001, CC_LOOPBACK};         // arg bits are echoed untouched
        rd = {27'h0, CC_RD_REG};
        wr = {27'h0, CC_WR_REG};
        z  = 32'h0;
        set_test(0, 5, 32'h1001, lb, 32'h11, 32'h22, 5, 32'h1001, lb, 32'h11, 32'h22, z, 0);
        frame[0][4] = 32'h33;
        expect_w[0][4] = 32'h33;
        set_test(1, 2, 32'h1002, lb, z, z, 2, 32'h1002, lb, z, z, z, 0);  // empty payload
        set_test(2, 4, 32'h1003, wr, REG_SCRATCH, 32'hdead_beef, 2, 32'h1003, wr, z, z, z, 0);
        set_test(3, 3, 32'h1004, rd, REG_SCRATCH, z, 3, 32'h1004, rd, 32'hdead_beef, z, z, 0);
        set_test(4, 4, 32'h1005, wr, REG_NUM_BURSTS, 32'hffff_ffff, 2, 32'h1005, wr, z, z, z, 0);
        set_test(5, 4, 32'h1006, wr, REG_WAVEFORM_GAP, 32'ha5a5_a5a5, 2, 32'h1006, wr, z, z, z, 0);
        set_test(6, 3, 32'h1007, rd, REG_NUM_BURSTS, z, 3, 32'h1007, rd, 32'h007f_ffff, z, z, 0);
        set_test(7, 3, 32'h1008, rd, REG_WAVEFORM_GAP, z, 3, 32'h1008, rd, 32'h0025_a5a5,
                 z, z, 0);
        set_test(8, 4, 32'h1009, wr, REG_FW_ID, 32'h1111_1111, 2, 32'h1009, wr, z, z, z, 0);
        set_test(9, 3, 32'h100a, rd, REG_FW_ID, z, 3, 32'h100a, rd, FW_ID_VALUE, z, z, 0);
        set_test(10, 3, 32'h100b, rd, REG_XADC_TEMP, z, 3, 32'h100b, rd, 32'h0000_3c5a,
                 z, z, 0);
        set_test(11, 3, 32'h100c, rd, 32'd7, z, 2, 32'h100c, ~rd, z, z, z, 0);  // illegal
        set_test(12, 4, 32'h100d, wr, 32'd7, 32'h0, 2, 32'h100d, ~wr, z, z, z, 0);
        set_test(13, 4, 32'h100e, 32'h1f, 32'h1, 32'h2, 0, z, z, z, z, z, 0);  // unknown code
        set_test(14, 1, 32'h100f, z, z, z, 0, z, z, z, z, z, 0);              // lone word
        set_test(15, 3, 32'h1010, lb, 32'h44, z, 3, 32'h1010, lb, 32'h44, z, z, 0);
        set_test(16, 5, 32'h1011, lb, 32'h11, 32'h22, 5, 32'h1011, lb, 32'h11, 32'h22, z, 1);
        frame[16][4] = 32'h33;
        expect_w[16][4] = 32'h33;
        set_test(17, 2, 32'h1012, lb, z, z, 2, 32'h1012, lb, z, z, z, 1);
        set_test(18, 4, 32'h1013, wr, REG_SCRATCH, 32'h0bad_cafe, 2, 32'h1013, wr, z, z, z, 1);
        set_test(19, 3, 32'h1014, rd, REG_SCRATCH, z, 3, 32'h1014, rd, 32'h0bad_cafe, z, z, 1);
        for (int t = 0; t < NT; t++) begin
            exp_bursts[t] = (t >= 4) ? 23'h7f_ffff : 23'h0;  // low bits of the write
            exp_gap[t]    = (t >= 5) ? 22'h25_a5a5 : 22'h0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // master model, called on a rising edge

    task automatic send_frame(input int t);
        for (int i = 0; i < flen[t]; i++) begin
            if (bp[t] && rx_gap) begin
                rx_tvalid <= 1'b0;                // gap before the next word
                @(posedge clk);
            end
            rx_data   <= frame[t][i];
            rx_tvalid <= 1'b1;
            rx_tlast  <= (i == flen[t] - 1);
            do @(posedge clk); while (!rx_tready);
        end
        rx_tvalid <= 1'b0;
        rx_tlast  <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int start_errors;
        int n;
        start_errors = errors;
        got_data.delete();
        got_last.delete();
        bp_on <= bp[t];
        send_frame(t);
        if (elen[t] == 0) begin
            repeat (50) @(posedge clk);           // nothing may come back
        end else begin
            while (got_data.size() < elen[t]) @(posedge clk);
            n = 0;
            while (!cmd_idle && n < 20) begin
                @(posedge clk);
                n++;
            end
            if (!cmd_idle) begin
                $display("test %0d: dispatcher did not return to idle", t);
                errors++;
            end
        end
        bp_on <= 1'b0;
        if (got_data.size() != elen[t]) begin
            $display("test %0d: expected %0d response words but received %0d",
                     t, elen[t], got_data.size());
            errors++;
        end
        for (int i = 0; i < elen[t] && i < got_data.size(); i++) begin
            check_word($sformatf("tx_data[%0d]", i), expect_w[t][i], got_data[i]);
            check_flag($sformatf("tx_tlast[%0d]", i), i == elen[t] - 1, got_last[i]);
        end
        check_config("num_bursts", exp_bursts[t], num_bursts);
        check_config("waveform_gap", BURSTS_W'(exp_gap[t]), BURSTS_W'(waveform_gap));
        if (errors == start_errors) begin
            $display("test %0d: ok", t);
        end else begin
            $display("test %0d: mismatch", t);
            failed_tests++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        rx_data   = '0;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        tx_tready = 1'b0;
        xadc_temp = TEMP_VALUE;
        fill_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        check_flag("tx_tvalid", 1'b0, tx_tvalid);   // ports quiet after reset
        check_flag("tx_tlast", 1'b0, tx_tlast);
        check_flag("rx_tready", 1'b0, rx_tready);
        check_flag("cmd_idle", 1'b1, cmd_idle);
        for (int t = 0; t < NT; t++) run_test(t);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NT, NT - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
